//--- hdl/scr1_mem_pkg.sv
// Data-side memory cluster definitions
// Bus widths, address map, timer register offsets and bus encodings
package scr1_mem_pkg;

    // ------------------------------------------------------------
    // Widths and address map
    // ------------------------------------------------------------
    localparam int unsigned SCR1_XLEN            = 32;
    localparam int unsigned SCR1_BE_WIDTH        = SCR1_XLEN / 8;     // Byte lanes per word

    localparam logic [SCR1_XLEN-1:0] SCR1_TCM_ADDR_MASK      = 32'hFFFFFC00;
    localparam logic [SCR1_XLEN-1:0] SCR1_TCM_ADDR_PATTERN   = 32'h00480000;
    localparam int unsigned          SCR1_TCM_WORDS          = 256;
    localparam int unsigned          SCR1_TCM_IDX_WIDTH      = $clog2(SCR1_TCM_WORDS);

    localparam logic [SCR1_XLEN-1:0] SCR1_TIMER_ADDR_MASK    = 32'hFFFFFFE0;
    localparam logic [SCR1_XLEN-1:0] SCR1_TIMER_ADDR_PATTERN = 32'h00490000;

    // Timer register byte offsets inside its 32-byte window
    localparam int unsigned SCR1_TIMER_OFFS_WIDTH = 5;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_CONTROL    = 5'h00;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_DIVIDER    = 5'h04;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_MTIMELO    = 5'h08;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_MTIMEHI    = 5'h0C;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_MTIMECMPLO = 5'h10;
    localparam logic [SCR1_TIMER_OFFS_WIDTH-1:0] SCR1_TIMER_OFFS_MTIMECMPHI = 5'h14;

    localparam int unsigned SCR1_TIMER_DIV_WIDTH  = 10;

    // ------------------------------------------------------------
    // Bus encodings
    // ------------------------------------------------------------
    typedef enum logic {
        SCR1_MEM_CMD_RD     = 1'b0,
        SCR1_MEM_CMD_WR     = 1'b1
    } type_scr1_mem_cmd_e;

    typedef enum logic [1:0] {
        SCR1_MEM_WIDTH_BYTE  = 2'b00,
        SCR1_MEM_WIDTH_HWORD = 2'b01,
        SCR1_MEM_WIDTH_WORD  = 2'b10
    } type_scr1_mem_width_e;

    typedef enum logic [1:0] {
        SCR1_MEM_RESP_NOTRDY = 2'b00,
        SCR1_MEM_RESP_RDY_OK = 2'b01,
        SCR1_MEM_RESP_RDY_ER = 2'b10
    } type_scr1_mem_resp_e;

    typedef enum logic [1:0] {
        SCR1_DMEM_TARGET_NONE  = 2'b00,      // Unmapped, answered by the router
        SCR1_DMEM_TARGET_TCM   = 2'b01,
        SCR1_DMEM_TARGET_TIMER = 2'b10
    } type_scr1_dmem_target_e;

endpackage : scr1_mem_pkg

//--- hdl/scr1_dmem_if.sv
`timescale 1ns/10ps
// Data-memory channel between the router and one target
// Request fields come from the master, ack and response from the slave
interface scr1_dmem_if;
    import scr1_mem_pkg::*;

    logic                       req;
    type_scr1_mem_cmd_e         cmd;
    type_scr1_mem_width_e       width;
    logic [SCR1_XLEN-1:0]       addr;
    logic [SCR1_XLEN-1:0]       wdata;     // Sub-word data on its addressed lanes
    logic                       req_ack;
    logic [SCR1_XLEN-1:0]       rdata;
    type_scr1_mem_resp_e        resp;      // NOTRDY except in the response cycle

    modport master (
        output req, cmd, width, addr, wdata,
        input  req_ack, rdata, resp
    );

    modport slave (
        input  req, cmd, width, addr, wdata,
        output req_ack, rdata, resp
    );

endinterface : scr1_dmem_if

//--- hdl/scr1_dmem_router.sv
`timescale 1ns/10ps
// Data-memory router
// Decodes each request to the TCM or the timer and returns the response
// of the target accepted in the previous cycle; unmapped space gets RDY_ER
module scr1_dmem_router (
    input  logic                                clk,
    input  logic                                core_rst_n_local,

    // Core side
    input  logic                                dmem_req_i,
    input  scr1_mem_pkg::type_scr1_mem_cmd_e    dmem_cmd_i,
    input  scr1_mem_pkg::type_scr1_mem_width_e  dmem_width_i,
    input  logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_addr_i,
    input  logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_wdata_i,
    output logic                                dmem_req_ack_o,
    output logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_rdata_o,
    output scr1_mem_pkg::type_scr1_mem_resp_e   dmem_resp_o,

    // Targets
    scr1_dmem_if.master                         tcm_if,
    scr1_dmem_if.master                         timer_if
);
    import scr1_mem_pkg::*;

    type_scr1_dmem_target_e     req_target;     // Decoded from the current address
    type_scr1_dmem_target_e     resp_target;    // Target of the request in flight
    logic                       resp_pending;
    logic                       req_accept;

    // ------------------------------------------------------------
    // Request side
    // ------------------------------------------------------------
    always_comb begin
        if ((dmem_addr_i & SCR1_TCM_ADDR_MASK) == SCR1_TCM_ADDR_PATTERN) begin
            req_target = SCR1_DMEM_TARGET_TCM;
        end else if ((dmem_addr_i & SCR1_TIMER_ADDR_MASK) == SCR1_TIMER_ADDR_PATTERN) begin
            req_target = SCR1_DMEM_TARGET_TIMER;
        end else begin
            req_target = SCR1_DMEM_TARGET_NONE;
        end
    end

    assign tcm_if.req     = dmem_req_i & (req_target == SCR1_DMEM_TARGET_TCM);
    assign tcm_if.cmd     = dmem_cmd_i;
    assign tcm_if.width   = dmem_width_i;
    assign tcm_if.addr    = dmem_addr_i;
    assign tcm_if.wdata   = dmem_wdata_i;

    assign timer_if.req   = dmem_req_i & (req_target == SCR1_DMEM_TARGET_TIMER);
    assign timer_if.cmd   = dmem_cmd_i;
    assign timer_if.width = dmem_width_i;
    assign timer_if.addr  = dmem_addr_i;
    assign timer_if.wdata = dmem_wdata_i;

    always_comb begin
        case (req_target)
            SCR1_DMEM_TARGET_TCM:   dmem_req_ack_o = tcm_if.req_ack;
            SCR1_DMEM_TARGET_TIMER: dmem_req_ack_o = timer_if.req_ack;
            default:                dmem_req_ack_o = 1'b1;   // Error path never stalls
        endcase
    end

    assign req_accept = dmem_req_i & dmem_req_ack_o;

    // Remember who owes the next response
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_pending <= 1'b0;
            resp_target  <= SCR1_DMEM_TARGET_NONE;
        end else begin
            resp_pending <= req_accept;
            if (req_accept) begin
                resp_target <= req_target;
            end
        end
    end

    // ------------------------------------------------------------
    // Return path
    // ------------------------------------------------------------
    always_comb begin
        dmem_resp_o  = SCR1_MEM_RESP_NOTRDY;
        dmem_rdata_o = '0;
        if (resp_pending) begin
            case (resp_target)
                SCR1_DMEM_TARGET_TCM: begin
                    dmem_resp_o  = tcm_if.resp;
                    dmem_rdata_o = tcm_if.rdata;
                end
                SCR1_DMEM_TARGET_TIMER: begin
                    dmem_resp_o  = timer_if.resp;
                    dmem_rdata_o = timer_if.rdata;
                end
                default: dmem_resp_o = SCR1_MEM_RESP_RDY_ER;
            endcase
        end
    end

    // A target only answers the cycle after it accepted a request
    a_tcm_resp_order : assert property (@(posedge clk) disable iff (~core_rst_n_local)
        (tcm_if.resp != SCR1_MEM_RESP_NOTRDY) |-> $past(tcm_if.req & tcm_if.req_ack));

    a_timer_resp_order : assert property (@(posedge clk) disable iff (~core_rst_n_local)
        (timer_if.resp != SCR1_MEM_RESP_NOTRDY) |-> $past(timer_if.req & timer_if.req_ack));

endmodule : scr1_dmem_router

//--- hdl/scr1_tcm.sv
`timescale 1ns/10ps
// Tightly coupled data memory, 1 KB single port
// Byte-lane writes, full-word read data one cycle after acceptance
module scr1_tcm (
    input  logic        clk,
    input  logic        core_rst_n_local,
    scr1_dmem_if.slave  dmem_if
);
    import scr1_mem_pkg::*;

    logic [SCR1_XLEN-1:0]           mem [0:SCR1_TCM_WORDS-1];
    logic [SCR1_TCM_IDX_WIDTH-1:0]  word_idx;
    logic [SCR1_BE_WIDTH-1:0]       byte_en;
    logic                           req_accept;
    logic                           tcm_wr;
    logic                           tcm_rd;
    logic [SCR1_XLEN-1:0]           rdata_q;
    type_scr1_mem_resp_e            resp_q;

    assign dmem_if.req_ack = 1'b1;           // Always ready
    assign req_accept      = dmem_if.req & dmem_if.req_ack;
    assign word_idx        = dmem_if.addr[SCR1_TCM_IDX_WIDTH+1:2];

    // Lane select from width and low address bits
    always_comb begin
        case (dmem_if.width)
            SCR1_MEM_WIDTH_BYTE:  byte_en = 4'b0001 << dmem_if.addr[1:0];
            SCR1_MEM_WIDTH_HWORD: byte_en = 4'b0011 << dmem_if.addr[1:0];
            SCR1_MEM_WIDTH_WORD:  byte_en = 4'b1111;
            default:              byte_en = 4'b0000;
        endcase
    end

    assign tcm_wr = req_accept & (dmem_if.cmd == SCR1_MEM_CMD_WR);
    assign tcm_rd = req_accept & (dmem_if.cmd == SCR1_MEM_CMD_RD);

    // ------------------------------------------------------------
    // Storage and read data
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (tcm_wr) begin
            for (int i = 0; i < SCR1_BE_WIDTH; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= dmem_if.wdata[8*i +: 8];
                end
            end
        end
        if (tcm_rd) begin
            rdata_q <= mem[word_idx];        // Old contents on a read
        end
    end

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_q <= SCR1_MEM_RESP_NOTRDY;
        end else if (req_accept) begin
            resp_q <= (|byte_en) ? SCR1_MEM_RESP_RDY_OK : SCR1_MEM_RESP_RDY_ER;
        end else begin
            resp_q <= SCR1_MEM_RESP_NOTRDY;
        end
    end

    assign dmem_if.rdata = rdata_q;
    assign dmem_if.resp  = resp_q;

    // Requester keeps sub-word accesses inside one word
    a_tcm_aligned : assert property (@(posedge clk) disable iff (~core_rst_n_local)
        dmem_if.req |-> ((dmem_if.width == SCR1_MEM_WIDTH_WORD)  ? (dmem_if.addr[1:0] == 2'b00) :
                         (dmem_if.width == SCR1_MEM_WIDTH_HWORD) ? ~dmem_if.addr[0] : 1'b1));

endmodule : scr1_tcm

//--- hdl/scr1_timer.sv
`timescale 1ns/10ps
// Memory-mapped machine timer
// Divided clk tick drives a 64-bit mtime; interrupt when mtime >= mtimecmp
// Word-only register access, anything else is answered with RDY_ER
module scr1_timer (
    input  logic            clk,
    input  logic            core_rst_n_local,
    scr1_dmem_if.slave      dmem_if,
    output logic [63:0]     timer_val_o,
    output logic            timer_irq_o
);
    import scr1_mem_pkg::*;

    logic                               ctrl_en;
    logic [SCR1_TIMER_DIV_WIDTH-1:0]    divider;
    logic [SCR1_TIMER_DIV_WIDTH-1:0]    div_cnt;
    logic [63:0]                        mtime;
    logic [63:0]                        mtimecmp;
    logic                               irq_q;
    logic                               tick;

    logic [SCR1_TIMER_OFFS_WIDTH-1:0]   offs;
    logic                               req_accept;
    logic                               reg_hit;
    logic                               reg_ok;
    logic                               wr_en;
    logic [SCR1_XLEN-1:0]               reg_rdata;
    logic [SCR1_XLEN-1:0]               rdata_q;
    type_scr1_mem_resp_e                resp_q;

    // ------------------------------------------------------------
    // Register access
    // ------------------------------------------------------------
    assign dmem_if.req_ack = 1'b1;
    assign req_accept      = dmem_if.req & dmem_if.req_ack;
    assign offs            = dmem_if.addr[SCR1_TIMER_OFFS_WIDTH-1:0];

    always_comb begin
        reg_hit   = 1'b1;
        reg_rdata = '0;
        case (offs)
            SCR1_TIMER_OFFS_CONTROL:    reg_rdata = {31'd0, ctrl_en};
            SCR1_TIMER_OFFS_DIVIDER:    reg_rdata = {{(SCR1_XLEN-SCR1_TIMER_DIV_WIDTH){1'b0}}, divider};
            SCR1_TIMER_OFFS_MTIMELO:    reg_rdata = mtime[31:0];
            SCR1_TIMER_OFFS_MTIMEHI:    reg_rdata = mtime[63:32];
            SCR1_TIMER_OFFS_MTIMECMPLO: reg_rdata = mtimecmp[31:0];
            SCR1_TIMER_OFFS_MTIMECMPHI: reg_rdata = mtimecmp[63:32];
            default:                    reg_hit   = 1'b0;
        endcase
    end

    assign reg_ok = reg_hit & (dmem_if.width == SCR1_MEM_WIDTH_WORD);
    assign wr_en  = req_accept & reg_ok & (dmem_if.cmd == SCR1_MEM_CMD_WR);

    always_ff @(posedge clk) begin
        if (req_accept) begin
            rdata_q <= reg_rdata;            // Sampled at acceptance
        end
    end

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            resp_q <= SCR1_MEM_RESP_NOTRDY;
        end else if (req_accept) begin
            resp_q <= reg_ok ? SCR1_MEM_RESP_RDY_OK : SCR1_MEM_RESP_RDY_ER;
        end else begin
            resp_q <= SCR1_MEM_RESP_NOTRDY;
        end
    end

    assign dmem_if.rdata = rdata_q;
    assign dmem_if.resp  = resp_q;

    // ------------------------------------------------------------
    // Control, divider and counter
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            ctrl_en  <= 1'b1;
            divider  <= '0;
            mtimecmp <= '1;
        end else if (wr_en) begin
            case (offs)
                SCR1_TIMER_OFFS_CONTROL:    ctrl_en         <= dmem_if.wdata[0];
                SCR1_TIMER_OFFS_DIVIDER:    divider         <= dmem_if.wdata[SCR1_TIMER_DIV_WIDTH-1:0];
                SCR1_TIMER_OFFS_MTIMECMPLO: mtimecmp[31:0]  <= dmem_if.wdata;
                SCR1_TIMER_OFFS_MTIMECMPHI: mtimecmp[63:32] <= dmem_if.wdata;
                default: ;                  // mtime halves handled below
            endcase
        end
    end

    assign tick = ctrl_en & (div_cnt == divider);

    // Prescaler restarts on enable off or a new divider
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            div_cnt <= '0;
        end else if (~ctrl_en | tick | (wr_en & (offs == SCR1_TIMER_OFFS_DIVIDER))) begin
            div_cnt <= '0;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            mtime <= '0;
        end else if (wr_en & (offs == SCR1_TIMER_OFFS_MTIMELO)) begin
            mtime[31:0]  <= dmem_if.wdata;   // Write wins over the tick
        end else if (wr_en & (offs == SCR1_TIMER_OFFS_MTIMEHI)) begin
            mtime[63:32] <= dmem_if.wdata;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    // One cycle behind the compare
    always_ff @(posedge clk) begin
        if (~core_rst_n_local) begin
            irq_q <= 1'b0;
        end else begin
            irq_q <= (mtime >= mtimecmp);
        end
    end

    assign timer_val_o = mtime;
    assign timer_irq_o = irq_q;

    a_timer_word_only : assert property (@(posedge clk) disable iff (~core_rst_n_local)
        (resp_q == SCR1_MEM_RESP_RDY_OK) |-> ($past(dmem_if.width) == SCR1_MEM_WIDTH_WORD));

endmodule : scr1_timer

//--- hdl/scr1_mem_cluster.sv
`timescale 1ns/10ps
// Data-side memory cluster top
// One data-memory port routed to the TCM, the machine timer or an error reply
module scr1_mem_cluster (
    input  logic                                clk,
    input  logic                                core_rst_n_local,

    // Data memory port
    input  logic                                dmem_req_i,
    input  scr1_mem_pkg::type_scr1_mem_cmd_e    dmem_cmd_i,
    input  scr1_mem_pkg::type_scr1_mem_width_e  dmem_width_i,
    input  logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_addr_i,
    input  logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_wdata_i,
    output logic                                dmem_req_ack_o,
    output logic [scr1_mem_pkg::SCR1_XLEN-1:0]  dmem_rdata_o,
    output scr1_mem_pkg::type_scr1_mem_resp_e   dmem_resp_o,

    // Timer
    output logic [63:0]                         timer_val_o,
    output logic                                timer_irq_o
);

    // ------------------------------------------------------------
    // Router to target channels
    // ------------------------------------------------------------
    scr1_dmem_if tcm_dmem_if ();
    scr1_dmem_if timer_dmem_if ();

    // ------------------------------------------------------------
    // Data memory router
    // ------------------------------------------------------------
    scr1_dmem_router i_dmem_router (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),

        .dmem_req_i         (dmem_req_i      ),
        .dmem_cmd_i         (dmem_cmd_i      ),
        .dmem_width_i       (dmem_width_i    ),
        .dmem_addr_i        (dmem_addr_i     ),
        .dmem_wdata_i       (dmem_wdata_i    ),
        .dmem_req_ack_o     (dmem_req_ack_o  ),
        .dmem_rdata_o       (dmem_rdata_o    ),
        .dmem_resp_o        (dmem_resp_o     ),

        .tcm_if             (tcm_dmem_if     ),
        .timer_if           (timer_dmem_if   )
    );

    // ------------------------------------------------------------
    // TCM
    // ------------------------------------------------------------
    scr1_tcm i_tcm (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .dmem_if            (tcm_dmem_if     )
    );

    // ------------------------------------------------------------
    // Machine timer
    // ------------------------------------------------------------
    scr1_timer i_timer (
        .clk                (clk             ),
        .core_rst_n_local   (core_rst_n_local),
        .dmem_if            (timer_dmem_if   ),
        .timer_val_o        (timer_val_o     ),   // Current mtime
        .timer_irq_o        (timer_irq_o     )
    );

endmodule : scr1_mem_cluster

//--- include/tb_mem_tasks.svh
// Testbench helpers for the data-side memory cluster
// Bus operation queue and its driver, LFSR stimulus and typed result checks
`ifndef TB_MEM_TASKS_SVH
`define TB_MEM_TASKS_SVH

// ------------------------------------------------------------
// Stimulus
// ------------------------------------------------------------
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};    // x^32 + x^22 + x^2 + x + 1
endfunction

function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_step(lfsr_state);
        v = {v[30:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic logic [31:0] tcm_addr(input logic [7:0] idx);
    return SCR1_TCM_ADDR_PATTERN | {22'd0, idx, 2'b00};
endfunction

function automatic logic [31:0] timer_addr(input logic [SCR1_TIMER_OFFS_WIDTH-1:0] offs);
    return SCR1_TIMER_ADDR_PATTERN | {27'd0, offs};
endfunction

function automatic void queue_write(input type_scr1_mem_width_e width,
                                    input logic [31:0] addr, input logic [31:0] wdata,
                                    input type_scr1_mem_resp_e resp);
    bus_op_t op;
    op = '{SCR1_MEM_CMD_WR, width, addr, wdata, resp, 32'd0};
    ops.push_back(op);
endfunction

function automatic void queue_read(input type_scr1_mem_width_e width,
                                   input logic [31:0] addr, input type_scr1_mem_resp_e resp,
                                   input logic [31:0] rdata);
    bus_op_t op;
    op = '{SCR1_MEM_CMD_RD, width, addr, 32'd0, resp, rdata};
    ops.push_back(op);
endfunction

// ------------------------------------------------------------
// Result checks
// ------------------------------------------------------------
task automatic check_resp(input type_scr1_mem_resp_e got, input type_scr1_mem_resp_e exp,
                          input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s gave %s, expected %s", $time, what, got.name(), exp.name());
        resp_errs++;
    end
endtask

task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s gave %h, expected %h", $time, what, got, exp);
        data_errs++;
    end
endtask

task automatic check_time(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
        $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        time_errs++;
    end
endtask

// ------------------------------------------------------------
// Issues the queued operations back to back, one per cycle
// ------------------------------------------------------------
task automatic run_ops();
    bus_op_t op;
    bus_op_t prev;
    bit      pending;
    int      waits;
    pending = 1'b0;
    while (ops.size() > 0 || pending) begin
        @(posedge clk);
        #1;
        dmem_req_i = (ops.size() > 0);
        if (dmem_req_i) begin
            op           = ops.pop_front();
            dmem_cmd_i   = op.cmd;
            dmem_width_i = op.width;
            dmem_addr_i  = op.addr;
            dmem_wdata_i = op.wdata;
        end
        @(negedge clk);                     // Response cycle of the previous request
        if (pending) begin
            check_resp(dmem_resp_o, prev.resp, $sformatf("access to %h", prev.addr));
            if (prev.cmd == SCR1_MEM_CMD_RD && prev.resp == SCR1_MEM_RESP_RDY_OK) begin
                check_word(dmem_rdata_o, prev.rdata, $sformatf("read of %h", prev.addr));
            end
        end
        pending = dmem_req_i;
        prev    = op;
        waits   = 0;
        while (dmem_req_i && !dmem_req_ack_o && waits < 8) begin
            @(negedge clk);
            waits++;
        end
        if (waits == 8) begin
            $display("Timeout: request to %h not acknowledged within 8 cycles", op.addr);
            timeouts++;
        end
    end
    @(negedge clk);
    check_resp(dmem_resp_o, SCR1_MEM_RESP_NOTRDY, "idle cycle after last response");
endtask

`endif

//--- test/tb_mem_cluster.sv
`timescale 1ns/10ps
// Directed testbench for the data-side memory cluster
// TCM lanes, unmapped space, timer registers, divider, interrupt and pipelining
module tb_mem_cluster;
    import scr1_mem_pkg::*;

    typedef struct packed {
        type_scr1_mem_cmd_e     cmd;
        type_scr1_mem_width_e   width;
        logic [31:0]            addr;
        logic [31:0]            wdata;
        type_scr1_mem_resp_e    resp;       // Expected code
        logic [31:0]            rdata;      // Expected data of an OK read
    } bus_op_t;

    logic                   clk;
    logic                   core_rst_n_local;
    logic                   dmem_req_i;
    type_scr1_mem_cmd_e     dmem_cmd_i;
    type_scr1_mem_width_e   dmem_width_i;
    logic [31:0]            dmem_addr_i;
    logic [31:0]            dmem_wdata_i;
    logic                   dmem_req_ack_o;
    logic [31:0]            dmem_rdata_o;
    type_scr1_mem_resp_e    dmem_resp_o;
    logic [63:0]            timer_val_o;
    logic                   timer_irq_o;

    bus_op_t                ops [$];
    logic [31:0]            shadow [0:255];     // TCM contents as written
    logic [31:0]            lfsr_state = 32'h1a1a4e93;
    int                     resp_errs = 0;
    int                     data_errs = 0;
    int                     time_errs = 0;
    int                     timeouts  = 0;

    scr1_mem_cluster dut0 (.*);

    `include "tb_mem_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_tcm_lanes();
        logic [7:0]  idx [$];
        logic [31:0] r;
        logic [31:0] data;
        logic [1:0]  lane;
        for (int n = 0; n < 8; n++) begin
            r    = rand_bits(8);
            data = rand_bits(32);
            idx.push_back(r[7:0]);
            shadow[r[7:0]] = data;
            queue_write(SCR1_MEM_WIDTH_WORD, tcm_addr(r[7:0]), data, SCR1_MEM_RESP_RDY_OK);
        end
        foreach (idx[n]) begin
            r    = rand_bits(2);
            data = rand_bits(32);
            lane = (n % 2 == 0) ? r[1:0] : {r[1], 1'b0};    // Halfwords on even lanes
            if (n % 2 == 0) begin
                shadow[idx[n]][8*lane +: 8] = data[8*lane +: 8];
                queue_write(SCR1_MEM_WIDTH_BYTE, tcm_addr(idx[n]) | {30'd0, lane}, data,
                            SCR1_MEM_RESP_RDY_OK);
            end else begin
                shadow[idx[n]][8*lane +: 16] = data[8*lane +: 16];
                queue_write(SCR1_MEM_WIDTH_HWORD, tcm_addr(idx[n]) | {30'd0, lane}, data,
                            SCR1_MEM_RESP_RDY_OK);
            end
        end
        foreach (idx[n]) begin
            queue_read(SCR1_MEM_WIDTH_WORD, tcm_addr(idx[n]), SCR1_MEM_RESP_RDY_OK,
                       shadow[idx[n]]);
        end
        run_ops();
    endtask

    task automatic test_unmapped();
        queue_write(SCR1_MEM_WIDTH_WORD, tcm_addr(8'd0), 32'h5a5a_c3c3, SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, 32'h0048_0400, 32'h1111_2222, SCR1_MEM_RESP_RDY_ER);
        queue_read(SCR1_MEM_WIDTH_WORD, 32'h0049_0020, SCR1_MEM_RESP_RDY_ER, '0);
        queue_write(SCR1_MEM_WIDTH_WORD, 32'h0000_0000, 32'h3333_4444, SCR1_MEM_RESP_RDY_ER);
        queue_read(SCR1_MEM_WIDTH_WORD, 32'hFFFF_FFFC, SCR1_MEM_RESP_RDY_ER, '0);
        queue_read(SCR1_MEM_WIDTH_WORD, tcm_addr(8'd0), SCR1_MEM_RESP_RDY_OK, 32'h5a5a_c3c3);
        run_ops();
    endtask

    task automatic test_timer_regs();
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_CONTROL),
                   SCR1_MEM_RESP_RDY_OK, 32'd1);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_DIVIDER),
                   SCR1_MEM_RESP_RDY_OK, 32'd0);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPLO),
                   SCR1_MEM_RESP_RDY_OK, 32'hFFFF_FFFF);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI),
                   SCR1_MEM_RESP_RDY_OK, 32'hFFFF_FFFF);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPLO),
                    32'h9abc_def0, SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI),
                    32'h8000_1234, SCR1_MEM_RESP_RDY_OK);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPLO),
                   SCR1_MEM_RESP_RDY_OK, 32'h9abc_def0);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI),
                   SCR1_MEM_RESP_RDY_OK, 32'h8000_1234);
        queue_read(SCR1_MEM_WIDTH_BYTE, timer_addr(SCR1_TIMER_OFFS_CONTROL),
                   SCR1_MEM_RESP_RDY_ER, '0);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(5'h18), SCR1_MEM_RESP_RDY_ER, '0);
        run_ops();
    endtask

    task automatic test_divider();
        logic [63:0] prev;
        int          gap;
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_CONTROL), 32'd0,
                    SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMELO), 32'h0000_1000,
                    SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMEHI), 32'd0,
                    SCR1_MEM_RESP_RDY_OK);
        run_ops();
        repeat (6) @(negedge clk);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMELO),
                   SCR1_MEM_RESP_RDY_OK, 32'h0000_1000);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMEHI),
                   SCR1_MEM_RESP_RDY_OK, 32'd0);
        run_ops();
        check_time(timer_val_o, 64'h1000, "mtime while disabled");
        // Divider 3, so one step every 4 cycles
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_DIVIDER), 32'd3,
                    SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_CONTROL), 32'd1,
                    SCR1_MEM_RESP_RDY_OK);
        run_ops();
        prev = timer_val_o;
        for (int n = 0; n < 5; n++) begin
            gap = 0;
            while (timer_val_o == prev && gap < 64) begin
                @(negedge clk);
                gap++;
            end
            if (gap == 64) begin
                $display("Timeout: mtime did not advance within 64 cycles");
                timeouts++;
            end
            check_time(timer_val_o, prev + 64'd1, "mtime step");
            if (n > 0 && gap != 4) begin
                $display("Fail %0t: mtime stepped after %0d cycles, expected 4", $time, gap);
                time_errs++;
            end
            prev = timer_val_o;
        end
    endtask

    task automatic test_irq();
        logic [63:0] cmp;
        int          cycles;
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_DIVIDER), 32'd0,
                    SCR1_MEM_RESP_RDY_OK);
        run_ops();
        cmp = timer_val_o + 64'd40;
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI), cmp[63:32],
                    SCR1_MEM_RESP_RDY_OK);
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPLO), cmp[31:0],
                    SCR1_MEM_RESP_RDY_OK);
        run_ops();
        cycles = 0;
        while (!timer_irq_o && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!timer_irq_o) begin
            $display("Timeout: timer interrupt did not rise within 200 cycles");
            timeouts++;
        end else if (timer_val_o < cmp) begin
            $display("Fail %0t: interrupt at mtime %h below mtimecmp %h", $time,
                     timer_val_o, cmp);
            time_errs++;
        end
        // Compare far ahead, interrupt drops by the idle cycle after the response
        queue_write(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI), 32'hFFFF_FFFF,
                    SCR1_MEM_RESP_RDY_OK);
        run_ops();
        if (timer_irq_o !== 1'b0) begin
            $display("Fail %0t: timer interrupt still high 2 cycles after the write", $time);
            time_errs++;
        end
    endtask

    task automatic test_pipeline();
        queue_write(SCR1_MEM_WIDTH_WORD, tcm_addr(8'h40), 32'hdead_beef, SCR1_MEM_RESP_RDY_OK);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_CONTROL),
                   SCR1_MEM_RESP_RDY_OK, 32'd1);
        queue_write(SCR1_MEM_WIDTH_WORD, 32'h1000_0000, 32'd0, SCR1_MEM_RESP_RDY_ER);
        queue_read(SCR1_MEM_WIDTH_WORD, tcm_addr(8'h40), SCR1_MEM_RESP_RDY_OK, 32'hdead_beef);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_DIVIDER),
                   SCR1_MEM_RESP_RDY_OK, 32'd0);
        queue_read(SCR1_MEM_WIDTH_WORD, 32'h0049_0100, SCR1_MEM_RESP_RDY_ER, '0);
        queue_write(SCR1_MEM_WIDTH_BYTE, tcm_addr(8'h40) | 32'd2, 32'h0055_0000,
                    SCR1_MEM_RESP_RDY_OK);
        queue_read(SCR1_MEM_WIDTH_WORD, timer_addr(SCR1_TIMER_OFFS_MTIMECMPHI),
                   SCR1_MEM_RESP_RDY_OK, 32'hFFFF_FFFF);
        queue_read(SCR1_MEM_WIDTH_BYTE, 32'h2000_0003, SCR1_MEM_RESP_RDY_ER, '0);
        queue_read(SCR1_MEM_WIDTH_WORD, tcm_addr(8'h40), SCR1_MEM_RESP_RDY_OK, 32'hde55_beef);
        run_ops();
    endtask

    // ------------------------------------------------------------
    // Sequence and report
    // ------------------------------------------------------------
    initial begin
        dmem_req_i       = 1'b0;
        dmem_cmd_i       = SCR1_MEM_CMD_RD;
        dmem_width_i     = SCR1_MEM_WIDTH_WORD;
        dmem_addr_i      = '0;
        dmem_wdata_i     = '0;
        core_rst_n_local = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_resp(dmem_resp_o, SCR1_MEM_RESP_NOTRDY, "response in reset");
        check_time(timer_val_o, 64'd0, "mtime in reset");
        if (timer_irq_o !== 1'b0) begin
            $display("Fail %0t: timer interrupt high in reset", $time);
            time_errs++;
        end
        @(posedge clk);
        #1;
        core_rst_n_local = 1'b1;

        test_tcm_lanes();
        test_unmapped();
        test_timer_regs();
        test_divider();
        test_irq();
        test_pipeline();

        $display("Errors: %0d response, %0d data, %0d timer, %0d timeouts",
                 resp_errs, data_errs, time_errs, timeouts);
        if (resp_errs + data_errs + time_errs + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule : tb_mem_cluster

//--- tb.f
+incdir+include
hdl/scr1_mem_pkg.sv
hdl/scr1_dmem_if.sv
hdl/scr1_dmem_router.sv
hdl/scr1_tcm.sv
hdl/scr1_timer.sv
hdl/scr1_mem_cluster.sv
test/tb_mem_cluster.sv

//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_mem_cluster
FILELIST ?= tb.f
OBJ_DIR  ?= obj_dir
PASS_MSG  = Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
